// ==== src/cpu_config.svh ====
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// Data and address width.
`define WORD_SIZE 16

// Words per cache line; the memory line bus is this many words wide.
`define LINE_WORDS 4

// Lines per cache.
`define CACHE_LINES 4

`endif

// ==== src/isa_pkg.sv ====
package isa_pkg;

	// The opcode lives in the top nibble of every instruction.
	typedef enum logic [3:0] {
		ADD = 4'h0, // rd = rd + rs.
		ADI = 4'h1, // rd = rd + sext(imm).
		LWD = 4'h2,
		SWD = 4'h3,
		BNE = 4'h4,
		JMP = 4'h5, // Absolute target, zero-extended.
		WWD = 4'h6,
		HLT = 4'h7
	} opcode_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Instruction word layout, MSB first.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef struct packed {
		opcode_t    opcode;
		logic [1:0] rd;
		logic [1:0] rs;
		logic [7:0] imm;
	} instr_t;

endpackage

// ==== src/mem_pkg.sv ====
`include "cpu_config.svh"

package mem_pkg;

	localparam int OFFSET_BITS = $clog2(`LINE_WORDS);
	localparam int INDEX_BITS = $clog2(`CACHE_LINES);
	localparam int TAG_BITS = `WORD_SIZE - INDEX_BITS - OFFSET_BITS;

	// Word 0 of a line sits in the lowest bits.
	typedef logic [`LINE_WORDS-1:0][`WORD_SIZE-1:0] line_t;

	// A word address splits as {tag, index, offset}.
	typedef logic [TAG_BITS-1:0] tag_t;
	typedef logic [INDEX_BITS-1:0] index_t;
	typedef logic [OFFSET_BITS-1:0] offset_t;

endpackage

// ==== src/mem_if.sv ====
`timescale 1ns/1ps
`include "cpu_config.svh"

// Instruction fetch port between the datapath and the instruction cache.
interface fetch_if;
	logic                  read;
	logic [`WORD_SIZE-1:0] address;
	logic [`WORD_SIZE-1:0] rdata;
	logic                  ready; // One-cycle pulse, rdata valid with it.

	modport datapath (output read, output address, input rdata, input ready);
	modport cache (input read, input address, output rdata, output ready);
endinterface

// Load/store port between the datapath and the data cache.
interface data_if;
	logic                  read;
	logic                  write;
	logic [`WORD_SIZE-1:0] address;
	logic [`WORD_SIZE-1:0] wdata;
	logic [`WORD_SIZE-1:0] rdata;
	logic                  ready;

	modport datapath (output read, output write, output address, output wdata,
		input rdata, input ready);
	modport cache (input read, input write, input address, input wdata,
		output rdata, output ready);
endinterface

// ==== src/datapath.sv ====
`timescale 1ns/1ps
`include "cpu_config.svh"

module datapath (
	input  logic                  clk,
	input  logic                  rst,
	fetch_if.datapath             fetch,
	data_if.datapath              dmem,
	output logic [`WORD_SIZE-1:0] num_inst,
	output logic [`WORD_SIZE-1:0] output_port,
	output logic                  is_halted
);

	typedef enum logic [1:0] {FETCH, EXEC, MEM, HALT} state_t;

	state_t                state;
	isa_pkg::instr_t       ir;
	logic [`WORD_SIZE-1:0] pc;
	logic [`WORD_SIZE-1:0] regs [4];
	logic [`WORD_SIZE-1:0] rd_val;
	logic [`WORD_SIZE-1:0] rs_val;
	logic [`WORD_SIZE-1:0] imm_ext;
	logic [`WORD_SIZE-1:0] alu_result;
	logic [`WORD_SIZE-1:0] eff_addr;
	logic [`WORD_SIZE-1:0] next_pc;
	logic                  is_mem_op;
	logic                  retire;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Decode and execute.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign rd_val = regs[ir.rd];
	assign rs_val = regs[ir.rs];
	assign imm_ext = {{(`WORD_SIZE-8){ir.imm[7]}}, ir.imm};
	assign eff_addr = rs_val + imm_ext;
	assign is_mem_op = (ir.opcode == isa_pkg::LWD) || (ir.opcode == isa_pkg::SWD);

	always_comb begin
		alu_result = rd_val + imm_ext; // ADI unless overridden.
		next_pc = pc + 1'b1;
		case (ir.opcode)
			isa_pkg::ADD: alu_result = rd_val + rs_val;
			isa_pkg::BNE: begin
				if (rd_val != rs_val)
					next_pc = pc + 1'b1 + imm_ext;
			end
			isa_pkg::JMP: next_pc = {{(`WORD_SIZE-8){1'b0}}, ir.imm};
			default: ;
		endcase
	end

	// An instruction retires in execute, or when its memory access completes.
	assign retire = (state == EXEC && !is_mem_op) || (state == MEM && dmem.ready);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Cache requests.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign fetch.read = (state == FETCH);
	assign fetch.address = pc; // PC only moves in execute, so it holds while fetching.
	assign dmem.read = (state == MEM) && (ir.opcode == isa_pkg::LWD);
	assign dmem.write = (state == MEM) && (ir.opcode == isa_pkg::SWD);
	assign dmem.address = eff_addr;
	assign dmem.wdata = rd_val;

	assign is_halted = (state == HALT);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= FETCH;
			pc <= '0;
			num_inst <= '0;
			output_port <= '0;
			for (int i = 0; i < 4; i++)
				regs[i] <= '0;
		end else begin
			if (retire)
				num_inst <= num_inst + 1'b1;
			case (state)
				FETCH: begin
					if (fetch.ready)
						state <= EXEC;
				end
				EXEC: begin
					pc <= next_pc;
					case (ir.opcode)
						isa_pkg::ADD, isa_pkg::ADI: regs[ir.rd] <= alu_result;
						isa_pkg::WWD: output_port <= rd_val;
						default: ;
					endcase
					if (ir.opcode == isa_pkg::HLT)
						state <= HALT;
					else if (is_mem_op)
						state <= MEM;
					else
						state <= FETCH;
				end
				MEM: begin
					if (dmem.ready) begin
						if (ir.opcode == isa_pkg::LWD)
							regs[ir.rd] <= dmem.rdata;
						state <= FETCH;
					end
				end
				default: ; // Halted until the next reset.
			endcase
		end
	end

	// The instruction register loads with the fetched word.
	always_ff @(posedge clk) begin
		if (state == FETCH && fetch.ready)
			ir <= isa_pkg::instr_t'(fetch.rdata);
	end

endmodule

// ==== src/instr_cache.sv ====
`timescale 1ns/1ps
`include "cpu_config.svh"

module instr_cache (
	input  logic                  clk,
	input  logic                  rst,
	fetch_if.cache                cpu,
	output logic                  read_m1,
	output logic [`WORD_SIZE-1:0] address1,
	input  mem_pkg::line_t        data1,
	input  logic                  input_ready1
);

	typedef enum logic {IDLE, FILL} state_t;

	state_t                   state;
	logic [`CACHE_LINES-1:0]  valid;
	mem_pkg::tag_t            tags [`CACHE_LINES];
	mem_pkg::line_t           lines [`CACHE_LINES];
	mem_pkg::tag_t            tag;
	mem_pkg::index_t          idx;
	mem_pkg::offset_t         off;
	logic                     hit;
	logic                     lookup;
	logic                     fill_done;

	assign {tag, idx, off} = cpu.address;
	assign hit = valid[idx] && (tags[idx] == tag);
	// While ready is high the datapath has not yet dropped its read.
	assign lookup = (state == IDLE) && cpu.read && !cpu.ready;
	assign fill_done = (state == FILL) && input_ready1;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
			valid <= '0;
			read_m1 <= 1'b0;
			cpu.ready <= 1'b0;
		end else begin
			cpu.ready <= 1'b0;
			if (lookup && hit) begin
				cpu.ready <= 1'b1;
			end else if (lookup) begin
				state <= FILL;
				read_m1 <= 1'b1;
			end else if (fill_done) begin
				state <= IDLE;
				read_m1 <= 1'b0;
				valid[idx] <= 1'b1;
				cpu.ready <= 1'b1;
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Line storage and returned word.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk) begin
		if (lookup) begin
			cpu.rdata <= lines[idx][off];
			address1 <= {tag, idx, mem_pkg::offset_t'(0)}; // Line-aligned.
		end
		if (fill_done) begin
			lines[idx] <= data1;
			tags[idx] <= tag;
			cpu.rdata <= data1[off];
		end
	end

endmodule

// ==== src/data_cache.sv ====
`timescale 1ns/1ps
`include "cpu_config.svh"

module data_cache (
	input  logic                  clk,
	input  logic                  rst,
	data_if.cache                 cpu,
	output logic                  read_m2,
	output logic                  write_m2,
	output logic [`WORD_SIZE-1:0] address2,
	input  mem_pkg::line_t        data2_in,
	output mem_pkg::line_t        data2_out,
	input  logic                  input_ready2,
	input  logic                  ack_output2
);

	typedef enum logic [1:0] {IDLE, FILL, WRITE} state_t;

	state_t                   state;
	logic [`CACHE_LINES-1:0]  valid;
	mem_pkg::tag_t            tags [`CACHE_LINES];
	mem_pkg::line_t           lines [`CACHE_LINES];
	mem_pkg::tag_t            tag;
	mem_pkg::index_t          idx;
	mem_pkg::offset_t         off;
	logic                     hit;
	logic                     lookup;
	logic                     fill_done;

	assign {tag, idx, off} = cpu.address;
	assign hit = valid[idx] && (tags[idx] == tag);
	assign lookup = (state == IDLE) && (cpu.read || cpu.write) && !cpu.ready;
	assign fill_done = (state == FILL) && input_ready2;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Request control.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
			valid <= '0;
			read_m2 <= 1'b0;
			write_m2 <= 1'b0;
			cpu.ready <= 1'b0;
		end else begin
			cpu.ready <= 1'b0;
			case (state)
				IDLE: begin
					if (lookup && cpu.write) begin
						state <= WRITE; // Every store goes out to memory.
						write_m2 <= 1'b1;
					end else if (lookup && hit) begin
						cpu.ready <= 1'b1;
					end else if (lookup) begin
						state <= FILL;
						read_m2 <= 1'b1;
					end
				end
				FILL: begin
					if (input_ready2) begin
						state <= IDLE;
						read_m2 <= 1'b0;
						valid[idx] <= 1'b1;
						cpu.ready <= 1'b1;
					end
				end
				WRITE: begin
					if (ack_output2) begin
						state <= IDLE;
						write_m2 <= 1'b0;
						cpu.ready <= 1'b1;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Storage and memory payload.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk) begin
		if (lookup) begin
			cpu.rdata <= lines[idx][off];
			if (cpu.write) begin
				address2 <= cpu.address; // Full word address for a store.
				data2_out <= '0;
				data2_out[off] <= cpu.wdata;
				if (hit)
					lines[idx][off] <= cpu.wdata; // A store miss does not allocate.
			end else begin
				address2 <= {tag, idx, mem_pkg::offset_t'(0)};
			end
		end
		if (fill_done) begin
			lines[idx] <= data2_in;
			tags[idx] <= tag;
			cpu.rdata <= data2_in[off];
		end
	end

endmodule

// ==== src/cpu.sv ====
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpu (
	input  logic                  clk,
	input  logic                  rst,
	output logic                  read_m1,
	output logic [`WORD_SIZE-1:0] address1,
	input  mem_pkg::line_t        data1,
	input  logic                  input_ready1,
	output logic                  read_m2,
	output logic                  write_m2,
	output logic [`WORD_SIZE-1:0] address2,
	input  mem_pkg::line_t        data2_in,
	output mem_pkg::line_t        data2_out,
	input  logic                  input_ready2,
	input  logic                  ack_output2,
	output logic [`WORD_SIZE-1:0] num_inst,
	output logic [`WORD_SIZE-1:0] output_port,
	output logic                  is_halted
);

	fetch_if fetch_bus ();
	data_if data_bus ();

	datapath dp (
		.clk         (clk),
		.rst         (rst),
		.fetch       (fetch_bus),
		.dmem        (data_bus),
		.num_inst    (num_inst),
		.output_port (output_port),
		.is_halted   (is_halted)
	);

	// Each cache owns its own memory port.
	instr_cache i_cache (
		.clk          (clk),
		.rst          (rst),
		.cpu          (fetch_bus),
		.read_m1      (read_m1),
		.address1     (address1),
		.data1        (data1),
		.input_ready1 (input_ready1)
	);

	data_cache d_cache (
		.clk          (clk),
		.rst          (rst),
		.cpu          (data_bus),
		.read_m2      (read_m2),
		.write_m2     (write_m2),
		.address2     (address2),
		.data2_in     (data2_in),
		.data2_out    (data2_out),
		.input_ready2 (input_ready2),
		.ack_output2  (ack_output2)
	);

endmodule

// ==== verif/tb_memory.sv ====
`timescale 1ns/1ps
`include "cpu_config.svh"

module tb_memory (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  read_m1,
	input  logic [`WORD_SIZE-1:0] address1,
	output mem_pkg::line_t        data1,
	output logic                  input_ready1,
	input  logic                  read_m2,
	input  logic                  write_m2,
	input  logic [`WORD_SIZE-1:0] address2,
	output mem_pkg::line_t        data2_in,
	input  mem_pkg::line_t        data2_out,
	output logic                  input_ready2,
	output logic                  ack_output2
);

	logic [`WORD_SIZE-1:0] mem [256];
	logic [31:0]           lfsr = 32'h011a6eed;

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	// Three fresh bits give 0 to 7, folded onto 1 to 6 cycles.
	task automatic draw_delay(output int cycles);
		logic [2:0] bits;
		bits = '0;
		for (int b = 0; b < 3; b++) begin
			lfsr = lfsr_step(lfsr);
			bits = {bits[1:0], lfsr[0]};
		end
		cycles = (int'(bits) % 6) + 1;
	endtask

	task automatic wait_cycles(input int cycles, output logic aborted);
		aborted = 1'b0;
		for (int c = 0; c < cycles; c++) begin
			@(posedge clk);
			#1;
			if (rst)
				aborted = 1'b1; // A reset cancels the pending answer.
		end
	endtask

	function automatic mem_pkg::line_t line_at(input logic [`WORD_SIZE-1:0] addr);
		mem_pkg::line_t line;
		for (int w = 0; w < `LINE_WORDS; w++)
			line[w] = mem[{addr[7:2], 2'(w)}];
		return line;
	endfunction

	task automatic write_word(input logic [7:0] addr, input logic [`WORD_SIZE-1:0] data);
		mem[addr] = data;
	endtask

	task automatic read_word(input logic [7:0] addr, output logic [`WORD_SIZE-1:0] data);
		data = mem[addr];
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Memory ports.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	initial begin : instr_port
		int   cycles;
		logic aborted;
		input_ready1 = 1'b0;
		data1 = '0;
		forever begin
			@(posedge clk);
			#1;
			input_ready1 = 1'b0;
			if (read_m1 && !rst) begin
				draw_delay(cycles);
				wait_cycles(cycles, aborted);
				if (!aborted) begin
					data1 = line_at(address1);
					input_ready1 = 1'b1;
				end
			end
		end
	end

	initial begin : data_port
		int   cycles;
		logic aborted;
		input_ready2 = 1'b0;
		ack_output2 = 1'b0;
		data2_in = '0;
		forever begin
			@(posedge clk);
			#1;
			input_ready2 = 1'b0;
			ack_output2 = 1'b0;
			if ((read_m2 || write_m2) && !rst) begin
				draw_delay(cycles);
				wait_cycles(cycles, aborted);
				if (!aborted && write_m2) begin
					mem[address2[7:0]] = data2_out[address2[1:0]]; // Only the addressed lane.
					ack_output2 = 1'b1;
				end else if (!aborted) begin
					data2_in = line_at(address2);
					input_ready2 = 1'b1;
				end
			end
		end
	end

endmodule

// ==== verif/tb_top.sv ====
`timescale 1ns/1ps
`include "cpu_config.svh"

module tb_top;

	localparam int NUM_TESTS = 6;
	localparam int MAX_CYCLES = 200 * 30; // Cycles allowed per test before it counts as hung.
	localparam int LOOP_N = 5;

	logic                  clk;
	logic                  rst;
	logic                  read_m1;
	logic [`WORD_SIZE-1:0] address1;
	mem_pkg::line_t        data1;
	logic                  input_ready1;
	logic                  read_m2;
	logic                  write_m2;
	logic [`WORD_SIZE-1:0] address2;
	mem_pkg::line_t        data2_in;
	mem_pkg::line_t        data2_out;
	logic                  input_ready2;
	logic                  ack_output2;
	logic [`WORD_SIZE-1:0] num_inst;
	logic [`WORD_SIZE-1:0] output_port;
	logic                  is_halted;

	string                 test_name [NUM_TESTS];
	int                    test_prog [NUM_TESTS];
	logic [`WORD_SIZE-1:0] exp_output [NUM_TESTS];
	logic [`WORD_SIZE-1:0] exp_count [NUM_TESTS];
	logic [7:0]            check_addr [NUM_TESTS];
	logic [`WORD_SIZE-1:0] exp_word [NUM_TESTS];
	logic [7:0]            load_addr;
	int                    errors;
	int                    passed;
	int                    failed;

	cpu UUT (.*);

	tb_memory memory (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial begin : watchdog
		#(NUM_TESTS * MAX_CYCLES * 4);
		$display("Timeout: the tests did not finish in the allowed time");
		$display("CHECKS FAILED");
		$finish;
	end

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	// Memory contents outside the programs, unique per address.
	function automatic logic [`WORD_SIZE-1:0] background(input logic [7:0] addr);
		return {~addr, addr};
	endfunction

	task automatic report_mismatch(input string name, input logic [`WORD_SIZE-1:0] expected,
		input logic [`WORD_SIZE-1:0] actual);
		$display("Error %s expected %h actual %h", name, expected, actual);
		errors++;
	endtask

	task automatic emit(input isa_pkg::opcode_t op, input logic [1:0] rd, input logic [1:0] rs,
		input logic [7:0] imm);
		memory.write_word(load_addr, {op, rd, rs, imm});
		load_addr = load_addr + 8'd1;
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Programs and test table.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic load_program(input int prog);
		for (int a = 0; a < 256; a++)
			memory.write_word(8'(a), background(8'(a)));
		load_addr = '0;
		case (prog)
			0: begin
				emit(isa_pkg::ADI, 2'd1, 2'd0, 8'd5);
				emit(isa_pkg::ADI, 2'd2, 2'd0, 8'hfd);
				emit(isa_pkg::ADD, 2'd1, 2'd2, 8'd0);
				emit(isa_pkg::ADI, 2'd3, 2'd0, 8'h64);
				emit(isa_pkg::ADD, 2'd3, 2'd1, 8'd0);
				emit(isa_pkg::ADD, 2'd3, 2'd3, 8'd0);
				emit(isa_pkg::WWD, 2'd3, 2'd0, 8'd0);
			end
			1: begin
				emit(isa_pkg::ADI, 2'd1, 2'd0, 8'h44);
				emit(isa_pkg::ADI, 2'd2, 2'd0, 8'h3c);
				emit(isa_pkg::SWD, 2'd2, 2'd1, 8'd0); // Store miss, no allocate.
				emit(isa_pkg::LWD, 2'd3, 2'd1, 8'd0);
				emit(isa_pkg::ADD, 2'd3, 2'd3, 8'd0);
				emit(isa_pkg::SWD, 2'd3, 2'd1, 8'd0); // Store hit.
				emit(isa_pkg::LWD, 2'd0, 2'd1, 8'd0);
				emit(isa_pkg::ADD, 2'd0, 2'd2, 8'd0);
				emit(isa_pkg::WWD, 2'd0, 2'd0, 8'd0);
			end
			2: begin
				memory.write_word(8'h40, 16'h1234);
				memory.write_word(8'h50, 16'h5678); // Same index as 0x40, other tag.
				emit(isa_pkg::LWD, 2'd1, 2'd0, 8'h40);
				emit(isa_pkg::LWD, 2'd2, 2'd0, 8'h50);
				emit(isa_pkg::LWD, 2'd3, 2'd0, 8'h40);
				emit(isa_pkg::ADD, 2'd3, 2'd1, 8'd0);
				emit(isa_pkg::ADD, 2'd3, 2'd2, 8'd0);
				emit(isa_pkg::WWD, 2'd3, 2'd0, 8'd0);
			end
			3: begin
				emit(isa_pkg::ADI, 2'd1, 2'd0, 8'(LOOP_N));
				emit(isa_pkg::ADI, 2'd2, 2'd0, 8'd0);
				emit(isa_pkg::ADI, 2'd3, 2'd0, 8'd7);
				emit(isa_pkg::ADD, 2'd2, 2'd3, 8'd0);
				emit(isa_pkg::ADI, 2'd1, 2'd0, 8'hff);
				emit(isa_pkg::BNE, 2'd1, 2'd0, 8'hfd); // Back to the ADD.
				emit(isa_pkg::WWD, 2'd2, 2'd0, 8'd0);
			end
			4: begin
				emit(isa_pkg::ADI, 2'd1, 2'd0, 8'h11);
				emit(isa_pkg::ADI, 2'd2, 2'd0, 8'h7f);
				emit(isa_pkg::JMP, 2'd0, 2'd0, 8'd5);
				emit(isa_pkg::WWD, 2'd2, 2'd0, 8'd0); // Poisoned output, skipped.
				emit(isa_pkg::HLT, 2'd0, 2'd0, 8'd0);
				emit(isa_pkg::ADD, 2'd1, 2'd1, 8'd0);
				emit(isa_pkg::WWD, 2'd1, 2'd0, 8'd0);
			end
			default: begin
				emit(isa_pkg::ADI, 2'd1, 2'd0, 8'd9);
				emit(isa_pkg::WWD, 2'd1, 2'd0, 8'd0);
			end
		endcase
		emit(isa_pkg::HLT, 2'd0, 2'd0, 8'd0);
	endtask

	task automatic add_test(input int t, input string name, input int prog,
		input logic [`WORD_SIZE-1:0] out, input logic [`WORD_SIZE-1:0] count,
		input logic [7:0] addr, input logic [`WORD_SIZE-1:0] word);
		test_name[t] = name;
		test_prog[t] = prog;
		exp_output[t] = out;
		exp_count[t] = count;
		check_addr[t] = addr;
		exp_word[t] = word;
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Test flow.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic reset_and_check(input string name);
		rst = 1'b1;
		repeat (4) next_cycle();
		rst = 1'b0;
		assert (num_inst == '0) else report_mismatch({name, ".reset_num_inst"}, '0, num_inst);
		assert (output_port == '0) else report_mismatch({name, ".reset_output"}, '0, output_port);
		assert (!is_halted && !read_m1 && !read_m2 && !write_m2) else begin
			$display("%s: halt flag or a memory request is still high after reset", name);
			errors++;
		end
	endtask

	task automatic run_test(input int t);
		int                    cycles;
		int                    errors_before;
		logic [`WORD_SIZE-1:0] word;
		errors_before = errors;
		load_program(test_prog[t]);
		reset_and_check(test_name[t]);
		cycles = 0;
		while (!is_halted && cycles < MAX_CYCLES) begin
			next_cycle();
			cycles++;
		end
		assert (is_halted) else begin
			$display("%s: the CPU did not halt within %0d cycles", test_name[t], MAX_CYCLES);
			errors++;
		end
		assert (output_port == exp_output[t])
		else report_mismatch({test_name[t], ".output_port"}, exp_output[t], output_port);
		assert (num_inst == exp_count[t])
		else report_mismatch({test_name[t], ".num_inst"}, exp_count[t], num_inst);
		memory.read_word(check_addr[t], word);
		assert (word == exp_word[t])
		else report_mismatch({test_name[t], ".memory"}, exp_word[t], word);
		// Once halted the CPU must stay quiet.
		for (int c = 0; c < 20 && is_halted; c++) begin
			next_cycle();
			assert (is_halted && !read_m1 && !read_m2 && !write_m2) else begin
				$display("%s: a memory request or a halt drop was seen after HLT", test_name[t]);
				errors++;
			end
		end
		if (errors == errors_before) begin
			passed++;
			$display("%s passed", test_name[t]);
		end else begin
			failed++;
			$display("%s failed", test_name[t]);
		end
	endtask

	initial begin
		rst = 1'b1;
		errors = 0;
		passed = 0;
		failed = 0;
		load_addr = '0;
		add_test(0, "arithmetic", 0, 16'h00cc, 16'd8, 8'h40, background(8'h40));
		add_test(1, "store_load", 1, 16'h00b4, 16'd10, 8'h44, 16'h0078);
		add_test(2, "line_conflict", 2, 16'h7ae0, 16'd7, 8'h50, 16'h5678);
		add_test(3, "counted_loop", 3, 16'(7 * LOOP_N), 16'(3 + 3 * LOOP_N + 2), 8'h60,
			background(8'h60));
		add_test(4, "jump", 4, 16'h0022, 16'd6, 8'h40, background(8'h40));
		add_test(5, "halt_reset", 5, 16'h0009, 16'd3, 8'h7f, background(8'h7f));
		for (int t = 0; t < NUM_TESTS; t++)
			run_test(t);
		reset_and_check("final");
		$display("Tests passed %0d failed %0d", passed, failed);
		if (errors == 0 && failed == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

// ==== verilog.f ====
+incdir+src
src/isa_pkg.sv
src/mem_pkg.sv
src/mem_if.sv
src/datapath.sv
src/instr_cache.sv
src/data_cache.sv
src/cpu.sv
verif/tb_memory.sv
verif/tb_top.sv

// ==== run_sim.sh ====
#!/bin/sh

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module tb_top \
	-f verilog.f -o tb_sim > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
	cat build.log
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "ALL CHECKS PASSED" sim.log; then
	exit 0
fi
exit 1
